// File: project.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_tb;

    localparam logic [31:0] SEED       = 32'ha5ed67c1;
    localparam int          PROG_LEN   = 200;
    localparam int          MEM_WORDS  = 256;
    localparam int          MAX_CYCLES = 4 * PROG_LEN + 100;
    localparam logic [31:0] END_PC     = 32'(4 * (PROG_LEN - 1));
    localparam logic [31:0] NOP        = 32'h00000013;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid;
    logic [`RV_ILEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   pc;
    logic                  commit_valid;
    logic [`RV_XLEN-1:0]   commit_pc;
    logic [`RV_ILEN-1:0]   commit_inst;
    logic [`RV_RIDX_W-1:0] commit_rd_addr;
    logic [`RV_XLEN-1:0]   commit_rd_data;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;

    logic [31:0] mem [MEM_WORDS];
    logic        no_land [PROG_LEN];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] fetch_pc;
    int          cycle_cnt = 0;
    int          first_drive_cycle = 0;
    int          commit_count = 0;
    logic        done = 1'b0;
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    logic        exp_taken;
    logic [31:0] exp_target;

    rv_core u_rv_core (
        .clk              (clk),
        .rst              (rst),
        .inst_valid_i     (inst_valid),
        .inst_i           (inst),
        .pc_i             (pc),
        .commit_valid_o   (commit_valid),
        .commit_pc_o      (commit_pc),
        .commit_inst_o    (commit_inst),
        .commit_rd_addr_o (commit_rd_addr),
        .commit_rd_data_o (commit_rd_data),
        .redirect_o       (redirect),
        .redirect_pc_o    (redirect_pc)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // forward target that never lands inside a lui/addi/jalr group
    function automatic int pick_target(input int from, input int step);
        int t;
        t = from + 1 + step;
        if (t > PROG_LEN - 1) begin
            t = PROG_LEN - 1;
        end
        while (no_land[t]) begin
            t = t + 1;
        end
        return t;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        return mem[addr[9:2]];
    endfunction

    // built back to front so every forward target already exists
    task automatic build_program();
        logic [31:0] rng;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  base;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [31:0] addr;
        logic [31:0] hi;
        logic [31:0] lo;
        int          i;
        int          t;
        rng = SEED;
        for (int k = 0; k < MEM_WORDS; k++) begin
            // addi x0 tagged with its own address
            mem[k] = enc_i(12'(k * 4), 5'd0, 3'd0, 5'd0, 7'b0010011);
        end
        for (int k = 0; k < PROG_LEN; k++) begin
            no_land[k] = 1'b0;
        end
        mem[PROG_LEN - 1] = NOP;
        i = PROG_LEN - 2;
        while (i >= 0) begin
            rng  = xorshift(rng);
            kind = rng[3:0];
            rd   = {2'b00, rng[10:8]};
            rs1  = {2'b00, rng[13:11]};
            rs2  = {2'b00, rng[16:14]};
            f3   = rng[19:17];
            imm  = rng[31:20];
            if (kind == 4'd14 && i >= 2) begin
                t    = pick_target(i, int'(rng[22:20]));
                // odd sum so jalr must clear bit 0
                addr = 32'(t * 4 - 3);
                hi   = (addr + 32'h800) >> 12;
                lo   = addr - (hi << 12);
                base = {2'b00, rng[26:24] % 3'd7} + 5'd1;
                mem[i - 2] = {hi[19:0], base, 7'b0110111};
                mem[i - 1] = enc_i(lo[11:0], base, 3'b000, base, 7'b0010011);
                mem[i]     = enc_i(12'd4, base, 3'b000, rd, 7'b1100111);
                no_land[i - 1] = 1'b1;
                no_land[i]     = 1'b1;
                i = i - 3;
            end else begin
                if (kind < 4'd7) begin
                    mem[i] = enc_r({1'b0, rng[20] && (f3 == 3'b000 || f3 == 3'b101), 5'd0},
                                   rs2, rs1, f3, rd, 7'b0110011);
                end else if (kind == 4'd10) begin
                    mem[i] = {rng[31:12], rd, 7'b0110111};
                end else if (kind == 4'd11) begin
                    mem[i] = {rng[31:12], rd, 7'b0010111};
                end else if (kind == 4'd12) begin
                    t = pick_target(i, int'(rng[22:20]));
                    if (f3[2:1] == 2'b01) begin
                        f3 = f3 + 3'd2;
                    end
                    mem[i] = enc_b(13'((t - i) * 4), rs2, rs1, f3);
                end else if (kind == 4'd13) begin
                    t = pick_target(i, int'(rng[22:20]));
                    mem[i] = enc_j(21'((t - i) * 4), rd);
                end else if (kind == 4'd15) begin
                    // load opcode, not supported by the core
                    mem[i] = {rng[31:7], 7'b0000011};
                end else begin
                    if (f3 == 3'b001) begin
                        imm = {7'b0, imm[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    end
                    mem[i] = enc_i(imm, rs1, f3, rd, 7'b0010011);
                end
                i = i - 1;
            end
        end
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sra;
        logic [31:0]        r;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'd0, $signed(a) < $signed(b)};
            3'b011:  r = {31'd0, a < b};
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? sra : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // one step of sequential ISA execution on the model state
    function automatic void ref_step(output logic [31:0] e_pc, output logic [4:0] e_rd,
                                     output logic [31:0] e_val, output logic e_taken,
                                     output logic [31:0] e_target);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic        we;
        w        = fetch_word(model_pc);
        a        = model_regs[w[19:15]];
        b        = model_regs[w[24:20]];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_b    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        we       = 1'b1;
        res      = 32'd0;
        e_taken  = 1'b0;
        e_target = model_pc + imm_b;
        case (w[6:0])
            7'b0110011: res = alu(w[14:12], w[30], a, b);
            7'b0010011: res = alu(w[14:12], w[30] && (w[14:12] == 3'b101), a, imm_i);
            7'b0110111: res = {w[31:12], 12'd0};
            7'b0010111: res = model_pc + {w[31:12], 12'd0};
            7'b1101111: begin
                res      = model_pc + 32'd4;
                e_taken  = 1'b1;
                e_target = model_pc + imm_j;
            end
            7'b1100111: begin
                res      = model_pc + 32'd4;
                e_taken  = 1'b1;
                e_target = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                we      = 1'b0;
                e_taken = branch_cond(w[14:12], a, b);
            end
            default: we = 1'b0;
        endcase
        if (w[11:7] == 5'd0) begin
            we = 1'b0;
        end
        e_pc  = model_pc;
        e_rd  = we ? w[11:7] : 5'd0;
        e_val = we ? res : 32'd0;
        if (we) begin
            model_regs[w[11:7]] = res;
        end
        model_pc = e_taken ? e_target : model_pc + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // fetch agent that follows the redirect
    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        fetch_pc   = 32'd0;
        model_pc   = 32'd0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = 32'd0;
        end
        build_program();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        first_drive_cycle = cycle_cnt;
        forever begin
            if (redirect) begin
                // a strobe here would be discarded so restart next cycle
                fetch_pc   = redirect_pc;
                inst_valid = 1'b0;
            end else begin
                inst_valid = 1'b1;
                inst       = fetch_word(fetch_pc);
                pc         = fetch_pc;
                fetch_pc   = fetch_pc + 32'd4;
            end
            @(negedge clk);
        end
    end

    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            ref_step(exp_pc, exp_rd, exp_val, exp_taken, exp_target);
            if (commit_count == 0) begin
                check_value("first commit latency", 32'(first_drive_cycle + 2), 32'(cycle_cnt));
            end
            check_value("commit pc", exp_pc, commit_pc);
            check_value("commit inst", fetch_word(exp_pc), commit_inst);
            check_value("commit rd addr", 32'(exp_rd), 32'(commit_rd_addr));
            check_value("commit rd data", exp_val, commit_rd_data);
            check_value("redirect", 32'(exp_taken), 32'(redirect));
            if (exp_taken) begin
                check_value("redirect pc", exp_target, redirect_pc);
            end
            commit_count = commit_count + 1;
            if (exp_pc == END_PC) begin
                done = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout after %0d cycles, end of program never committed", cycle_cnt);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin
        wait (done);
        // let the checker sample the last commit
        @(negedge clk);
        if (u_rv_core.u_checker.fail_cnt == 0) begin
            $display("%0d instructions committed", commit_count);
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("bound checker saw %0d assertion failures", u_rv_core.u_checker.fail_cnt);
            $display("=== FAIL ===");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: dv/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_checker (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  commit_valid_i,
    input wire logic [`RV_ILEN-1:0]   commit_inst_i,
    input wire logic [`RV_RIDX_W-1:0] commit_rd_addr_i,
    input wire logic                  redirect_i
);

    int unsigned fail_cnt = 0;
    logic [6:0]  opcode;
    logic        writes_rd;
    logic        is_xfer;

    assign opcode = commit_inst_i[6:0];

    // only these opcodes write a register and never x0
    assign writes_rd = (commit_inst_i[11:7] != '0) &&
                       ((opcode == rv_pkg::OPC_OP) || (opcode == rv_pkg::OPC_OP_IMM) ||
                        (opcode == rv_pkg::OPC_LUI) || (opcode == rv_pkg::OPC_AUIPC) ||
                        (opcode == rv_pkg::OPC_JAL) || (opcode == rv_pkg::OPC_JALR));

    // control transfers are the only source of a redirect
    assign is_xfer = (opcode == rv_pkg::OPC_BRANCH) || (opcode == rv_pkg::OPC_JAL) ||
                     (opcode == rv_pkg::OPC_JALR);

    redirect_needs_commit: assert property (@(posedge clk) disable iff (rst)
        redirect_i |-> (commit_valid_i && is_xfer))
    else begin
        $error("redirect raised without a committing branch or jump");
        fail_cnt = fail_cnt + 1;
    end

    // both younger stages are squashed by the redirect
    no_commit_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !commit_valid_i)
    else begin
        $error("instruction committed in the cycle after a redirect");
        fail_cnt = fail_cnt + 1;
    end

    no_write_rd_zero: assert property (@(posedge clk) disable iff (rst)
        (commit_valid_i && !writes_rd) |-> (commit_rd_addr_i == '0))
    else begin
        $error("nonzero rd address on a commit that writes no register");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind rv_core rv_core_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .commit_valid_i   (commit_valid_o),
    .commit_inst_i    (commit_inst_o),
    .commit_rd_addr_i (commit_rd_addr_o),
    .redirect_i       (redirect_o)
);

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   inst_valid_i,
    input  wire logic [`RV_ILEN-1:0]    inst_i,
    input  wire logic [`RV_XLEN-1:0]    pc_i,
    output logic                        commit_valid_o,
    output logic      [`RV_XLEN-1:0]    commit_pc_o,
    output logic      [`RV_ILEN-1:0]    commit_inst_o,
    output logic      [`RV_RIDX_W-1:0]  commit_rd_addr_o,
    output logic      [`RV_XLEN-1:0]    commit_rd_data_o,
    output logic                        redirect_o,
    output logic      [`RV_XLEN-1:0]    redirect_pc_o
);

    rv_pkg::decoded_t     d_stage;
    rv_pkg::exec_result_t e_stage;
    logic [`RV_RIDX_W-1:0] rs1_addr;
    logic [`RV_RIDX_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    // redirect squashes both younger stages
    rv_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_o),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .d_stage_o    (d_stage)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_o),
        .d_stage_i    (d_stage),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .e_stage_o    (e_stage)
    );

    rv_result u_result (
        .clk              (clk),
        .rst              (rst),
        .e_stage_i        (e_stage),
        .rs1_addr_i       (rs1_addr),
        .rs2_addr_i       (rs2_addr),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .commit_valid_o   (commit_valid_o),
        .commit_pc_o      (commit_pc_o),
        .commit_inst_o    (commit_inst_o),
        .commit_rd_addr_o (commit_rd_addr_o),
        .commit_rd_data_o (commit_rd_data_o),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

`default_nettype wire

// File: hdl/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_result (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire rv_pkg::exec_result_t   e_stage_i,
    input  wire logic [`RV_RIDX_W-1:0]  rs1_addr_i,
    input  wire logic [`RV_RIDX_W-1:0]  rs2_addr_i,
    output logic      [`RV_XLEN-1:0]    rs1_data_o,
    output logic      [`RV_XLEN-1:0]    rs2_data_o,
    output logic                        commit_valid_o,
    output logic      [`RV_XLEN-1:0]    commit_pc_o,
    output logic      [`RV_ILEN-1:0]    commit_inst_o,
    output logic      [`RV_RIDX_W-1:0]  commit_rd_addr_o,
    output logic      [`RV_XLEN-1:0]    commit_rd_data_o,
    output logic                        redirect_o,
    output logic      [`RV_XLEN-1:0]    redirect_pc_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    // value about to commit takes priority over the array
    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic [`RV_RIDX_W-1:0] addr,
        input logic [`RV_XLEN-1:0]   rf_val,
        input rv_pkg::exec_result_t  e
    );
        logic [`RV_XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (e.valid && e.rd_we && (e.rd_addr == addr)) begin
            val = e.rd_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign wr_en = e_stage_i.valid && e_stage_i.rd_we && (e_stage_i.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[e_stage_i.rd_addr] <= e_stage_i.rd_data;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i, regs[rs1_addr_i], e_stage_i);
    assign rs2_data_o = read_port(rs2_addr_i, regs[rs2_addr_i], e_stage_i);

    // rd fields of the commit port read zero when nothing is written
    assign commit_valid_o   = e_stage_i.valid;
    assign commit_pc_o      = e_stage_i.pc;
    assign commit_inst_o    = e_stage_i.inst;
    assign commit_rd_addr_o = e_stage_i.rd_we ? e_stage_i.rd_addr : '0;
    assign commit_rd_data_o = e_stage_i.rd_we ? e_stage_i.rd_data : '0;

    // no prediction, so every taken transfer redirects
    assign redirect_o    = e_stage_i.valid && e_stage_i.taken;
    assign redirect_pc_o = e_stage_i.target;

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_execute (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush_i,
    input  wire rv_pkg::decoded_t       d_stage_i,
    input  wire logic [`RV_XLEN-1:0]    rs1_data_i,
    input  wire logic [`RV_XLEN-1:0]    rs2_data_i,
    output logic      [`RV_RIDX_W-1:0]  rs1_addr_o,
    output logic      [`RV_RIDX_W-1:0]  rs2_addr_o,
    output rv_pkg::exec_result_t        e_stage_o
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [SHAMT_W-1:0]  shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] jalr_sum;
    logic                is_jump;
    logic                taken;
    rv_pkg::exec_result_t res;

    // unused source ports read x0
    assign rs1_addr_o = d_stage_i.use_rs1 ? d_stage_i.rs1_addr : '0;
    assign rs2_addr_o = d_stage_i.use_rs2 ? d_stage_i.rs2_addr : '0;

    assign op_a  = d_stage_i.pc_sel ? d_stage_i.pc : rs1_data_i;
    assign op_b  = d_stage_i.imm_sel ? d_stage_i.imm : rs2_data_i;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (d_stage_i.alu_op)
            rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:          alu_res = op_b;
        endcase
    end

    // branch compare always uses the two register values
    always_comb begin
        case (d_stage_i.br_kind)
            rv_pkg::BR_BEQ:  taken = rs1_data_i == rs2_data_i;
            rv_pkg::BR_BNE:  taken = rs1_data_i != rs2_data_i;
            rv_pkg::BR_BLT:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            rv_pkg::BR_BGE:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            rv_pkg::BR_BLTU: taken = rs1_data_i < rs2_data_i;
            rv_pkg::BR_BGEU: taken = rs1_data_i >= rs2_data_i;
            rv_pkg::BR_JAL:  taken = 1'b1;
            rv_pkg::BR_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign is_jump  = (d_stage_i.br_kind == rv_pkg::BR_JAL) ||
                      (d_stage_i.br_kind == rv_pkg::BR_JALR);
    assign link     = d_stage_i.pc + `RV_XLEN'd4;
    assign jalr_sum = rs1_data_i + d_stage_i.imm;

    always_comb begin
        res.valid   = d_stage_i.valid;
        res.pc      = d_stage_i.pc;
        res.inst    = d_stage_i.inst;
        res.rd_addr = d_stage_i.rd_addr;
        res.rd_we   = d_stage_i.rd_we;
        res.rd_data = is_jump ? link : alu_res;
        res.taken   = taken;
        // jalr target has bit 0 forced low
        if (d_stage_i.br_kind == rv_pkg::BR_JALR) begin
            res.target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        end else begin
            res.target = d_stage_i.pc + d_stage_i.imm;
        end
    end

    always_ff @(posedge clk) begin
        e_stage_o <= res;
        if (rst || flush_i) begin
            e_stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module rv_decode (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush_i,
    input  wire logic                 inst_valid_i,
    input  wire logic [`RV_ILEN-1:0]  inst_i,
    input  wire logic [`RV_XLEN-1:0]  pc_i,
    output rv_pkg::decoded_t          d_stage_o
);

    rv_pkg::opcode_e  opcode;
    rv_pkg::decoded_t dec;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                rd_we_raw;

    // register-register and register-immediate share the funct3 map
    function automatic rv_pkg::alu_op_e alu_op_from(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign funct3 = inst_i[14:12];

    // immediates of every format in use, store format not needed
    assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-31){inst_i[31]}}, inst_i[30:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        case (inst_i[6:0])
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC,
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR, rv_pkg::OPC_BRANCH: begin
                opcode = rv_pkg::opcode_e'(inst_i[6:0]);
            end
            default: opcode = rv_pkg::OPC_NONE;
        endcase
    end

    always_comb begin
        dec          = '0;
        rd_we_raw    = 1'b0;
        dec.valid    = inst_valid_i;
        dec.pc       = pc_i;
        dec.inst     = inst_i;
        dec.rs1_addr = inst_i[19:15];
        dec.rs2_addr = inst_i[24:20];
        dec.rd_addr  = inst_i[11:7];
        dec.alu_op   = rv_pkg::ALU_ADD;
        dec.br_kind  = rv_pkg::BR_NONE;
        case (opcode)
            rv_pkg::OPC_OP: begin
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
                dec.alu_op  = alu_op_from(funct3, inst_i[30]);
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                dec.use_rs1 = 1'b1;
                dec.imm     = imm_i;
                dec.imm_sel = 1'b1;
                // only the right shifts use bit 30 as an alternate
                dec.alu_op  = alu_op_from(funct3, (funct3 == 3'b101) && inst_i[30]);
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                dec.imm     = imm_u;
                dec.imm_sel = 1'b1;
                dec.alu_op  = rv_pkg::ALU_PASS_B;
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.imm_sel = 1'b1;
                dec.pc_sel  = 1'b1;
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                dec.imm     = imm_j;
                dec.br_kind = rv_pkg::BR_JAL;
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                dec.use_rs1 = 1'b1;
                dec.imm     = imm_i;
                dec.br_kind = rv_pkg::BR_JALR;
                rd_we_raw   = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
                dec.imm     = imm_b;
                case (funct3)
                    3'b000:  dec.br_kind = rv_pkg::BR_BEQ;
                    3'b001:  dec.br_kind = rv_pkg::BR_BNE;
                    3'b100:  dec.br_kind = rv_pkg::BR_BLT;
                    3'b101:  dec.br_kind = rv_pkg::BR_BGE;
                    3'b110:  dec.br_kind = rv_pkg::BR_BLTU;
                    3'b111:  dec.br_kind = rv_pkg::BR_BGEU;
                    default: dec.br_kind = rv_pkg::BR_NONE;
                endcase
            end
            default: begin
                // unsupported opcode retires as a no-op
                rd_we_raw = 1'b0;
            end
        endcase
        dec.rd_we = rd_we_raw && (dec.rd_addr != '0);
    end

    always_ff @(posedge clk) begin
        d_stage_o <= dec;
        if (rst || flush_i) begin
            d_stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_NONE   = 7'b0000000,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_kind_e;

    // decode stage register
    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_ILEN-1:0]   inst;
        logic [`RV_RIDX_W-1:0] rs1_addr;
        logic [`RV_RIDX_W-1:0] rs2_addr;
        logic                  use_rs1;
        logic                  use_rs2;
        logic [`RV_RIDX_W-1:0] rd_addr;
        logic                  rd_we;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_e               alu_op;
        logic                  imm_sel;   // operand b from immediate
        logic                  pc_sel;    // operand a from pc
        br_kind_e              br_kind;
    } decoded_t;

    // execute stage register, committed by the result stage
    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_ILEN-1:0]   inst;
        logic [`RV_RIDX_W-1:0] rd_addr;
        logic                  rd_we;
        logic [`RV_XLEN-1:0]   rd_data;
        logic                  taken;
        logic [`RV_XLEN-1:0]   target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and pc width
`define RV_XLEN 32

// instruction word width
`define RV_ILEN 32

// architectural register count and index width
`define RV_NREGS 32
`define RV_RIDX_W 5

`endif
